// File: Bender.yml
package:
  name: fx_divider

sources:
  - src/fxdiv_pkg.sv
  - src/div_control.sv
  - src/div_iter_counter.sv
  - src/operand_prep.sv
  - src/restoring_div_core.sv
  - src/quotient_format.sv
  - src/fx_divider.sv
  - target: test
    files:
      - tb/fx_divider_assertions.sv
      - tb/fx_divider_tb.sv

// File: compile.f
src/fxdiv_pkg.sv
src/div_control.sv
src/div_iter_counter.sv
src/operand_prep.sv
src/restoring_div_core.sv
src/quotient_format.sv
src/fx_divider.sv
tb/fx_divider_assertions.sv
tb/fx_divider_tb.sv

// File: src/div_control.sv
`timescale 1ns/10ps

module div_control (
    input  logic clock,
    input  logic reset,

    // upstream side
    input  logic vld_in,
    output logic rdy_out,

    // downstream side
    input  logic rdy_in,
    output logic vld_out,

    // datapath sequencing
    input  logic last,      // counter is at the final step
    output logic accept,    // capture operands
    output logic start,     // load core and clear counter
    output logic step,      // one restoring iteration
    output logic finish     // load the output word
);

    typedef enum logic [1:0] {
        st_idle,
        st_load,
        st_run,
        st_hold
    } state_t;

    state_t state;
    state_t state_nxt;

    // ------------------------------------------------------------------------
    // next state
    // ------------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: if (accept) state_nxt = st_load;
            st_load: state_nxt = st_run;            // start only lasts one cycle
            st_run:  if (finish) state_nxt = st_hold;
            st_hold: if (rdy_in) state_nxt = st_idle; // result taken downstream
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // finish follows the last step edge by one cycle,
    // so the core register already holds the final quotient
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            finish <= 1'b0;
        end else begin
            finish <= step && last;
        end
    end

    // ------------------------------------------------------------------------
    // outputs
    // ------------------------------------------------------------------------
    assign rdy_out = (state == st_idle);    // one division in flight at most
    assign vld_out = (state == st_hold);
    assign accept  = vld_in && rdy_out;     // upstream transfer
    assign start   = (state == st_load);
    assign step    = (state == st_run) && !finish;

endmodule

// File: src/div_iter_counter.sv
`timescale 1ns/10ps

module div_iter_counter (
    input  logic clock,
    input  logic reset,
    input  logic start,     // clears the count
    input  logic step,      // advances by one
    output logic last       // final iteration in progress
);

    logic [fxdiv_pkg::cnt_w-1:0] count;

    // ------------------------------------------------------------------------
    // iteration count
    // ------------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (start) begin
            count <= '0;            // zero on the edge after start
        end else if (step) begin
            count <= count + 1'b1;  // runs to div_iters after the last step
        end
    end

    // high during the cycle of step number div_iters-1
    assign last = (count == fxdiv_pkg::cnt_w'(fxdiv_pkg::div_iters - 1));

endmodule

// File: src/fx_divider.sv
`timescale 1ns/10ps

module fx_divider (
    input  logic                               clock,
    input  logic                               reset,

    // upstream
    input  logic                               vld_in,
    output logic                               rdy_out,
    input  fxdiv_pkg::fx_in_u                  numerator,
    input  fxdiv_pkg::fx_in_u                  denominator,

    // downstream
    output logic                               vld_out,
    input  logic                               rdy_in,
    output logic signed [fxdiv_pkg::out_w-1:0] quotient
);

    logic                accept;
    logic                start;
    logic                step;
    logic                finish;
    logic                last;
    fxdiv_pkg::div_req_t req;   // registered signs and magnitudes
    fxdiv_pkg::div_res_t res;   // raw unsigned quotient

    // ------------------------------------------------------------------------
    // control
    // ------------------------------------------------------------------------
    div_control i_control (
        .clock   (clock),
        .reset   (reset),
        .vld_in  (vld_in),
        .rdy_out (rdy_out),
        .rdy_in  (rdy_in),
        .vld_out (vld_out),
        .last    (last),
        .accept  (accept),
        .start   (start),
        .step    (step),
        .finish  (finish)
    );

    div_iter_counter i_counter (
        .clock (clock),
        .reset (reset),
        .start (start),
        .step  (step),
        .last  (last)
    );

    // ------------------------------------------------------------------------
    // datapath
    // ------------------------------------------------------------------------
    operand_prep i_prep (
        .clock       (clock),
        .reset       (reset),
        .accept      (accept),
        .numerator   (numerator),
        .denominator (denominator),
        .req         (req)
    );

    restoring_div_core i_core (
        .clock (clock),
        .reset (reset),
        .start (start),
        .step  (step),
        .req   (req),
        .res   (res)
    );

    quotient_format i_format (
        .clock    (clock),
        .reset    (reset),
        .finish   (finish),
        .res      (res),
        .quotient (quotient)
    );

endmodule

// File: src/fxdiv_pkg.sv
package fxdiv_pkg;

    // ------------------------------------------------------------------------
    // number formats
    // ------------------------------------------------------------------------
    localparam int in_w     = 16;   // Q8.8 operands
    localparam int in_frac  = 8;
    localparam int out_w    = 16;   // Q4.12 quotient
    localparam int out_frac = 12;

    // magnitude of -32768 needs the full word, so no bit is dropped
    localparam int mag_w = in_w;

    // num and den fractions cancel, only the output fraction is shifted in
    localparam int frac_shift = out_frac - in_frac + in_frac;

    localparam int quo_w     = mag_w + frac_shift;      // 28 bit unsigned quotient
    localparam int div_iters = quo_w;                   // one quotient bit per step
    localparam int cnt_w     = $clog2(div_iters + 1);   // 5 bits, holds 0..28

    // ------------------------------------------------------------------------
    // operand word, read raw or as sign plus low bits
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic            sign;  // two's complement sign
        logic [in_w-2:0] low;
    } fx_fields_t;

    typedef union packed {
        logic signed [in_w-1:0] word;   // raw Q8.8 value
        fx_fields_t             fields;
    } fx_in_u;

    // ------------------------------------------------------------------------
    // datapath bundles
    // ------------------------------------------------------------------------
    // prep -> core
    typedef struct packed {
        logic             sign_q;   // num sign xor den sign
        logic [mag_w-1:0] num_mag;
        logic [mag_w-1:0] den_mag;
    } div_req_t;

    // core -> format
    typedef struct packed {
        logic             sign_q;
        logic [quo_w-1:0] quo_mag;  // floor(num_mag * 2^12 / den_mag)
    } div_res_t;

endpackage

// File: src/operand_prep.sv
`timescale 1ns/10ps

module operand_prep (
    input  logic                clock,
    input  logic                reset,
    input  logic                accept,         // upstream transfer this cycle
    input  fxdiv_pkg::fx_in_u   numerator,
    input  fxdiv_pkg::fx_in_u   denominator,
    output fxdiv_pkg::div_req_t req
);

    logic [fxdiv_pkg::mag_w-1:0] num_mag;
    logic [fxdiv_pkg::mag_w-1:0] den_mag;

    // ------------------------------------------------------------------------
    // magnitudes
    // ------------------------------------------------------------------------
    // 16 bit negate, 8000 stays 8000 which reads as 32768 unsigned
    always_comb begin
        if (numerator.fields.sign) begin
            num_mag = -numerator.word;
        end else begin
            num_mag = numerator.word;
        end

        if (denominator.fields.sign) begin
            den_mag = -denominator.word;
        end else begin
            den_mag = denominator.word;
        end
    end

    // ------------------------------------------------------------------------
    // request register
    // ------------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            req <= '0;
        end else if (accept) begin
            req.sign_q  <= numerator.fields.sign ^ denominator.fields.sign;
            req.num_mag <= num_mag;
            req.den_mag <= den_mag;     // zero passes through unchanged
        end
    end

endmodule

// File: src/quotient_format.sv
`timescale 1ns/10ps

module quotient_format (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              finish,   // core result is final
    input  fxdiv_pkg::div_res_t               res,
    output logic signed [fxdiv_pkg::out_w-1:0] quotient
);

    logic [fxdiv_pkg::out_w-1:0] lim;       // largest magnitude for this sign
    logic                        over;
    logic [fxdiv_pkg::out_w-1:0] sat_mag;
    logic [fxdiv_pkg::out_w-1:0] word;

    // ------------------------------------------------------------------------
    // saturate and re-sign
    // ------------------------------------------------------------------------
    always_comb begin
        // 32768 for negative results, 32767 for positive
        if (res.sign_q) begin
            lim = {1'b1, {(fxdiv_pkg::out_w-1){1'b0}}};
        end else begin
            lim = {1'b0, {(fxdiv_pkg::out_w-1){1'b1}}};
        end

        over = (res.quo_mag > fxdiv_pkg::quo_w'(lim));

        if (over) begin
            sat_mag = lim;
        end else begin
            sat_mag = res.quo_mag[fxdiv_pkg::out_w-1:0];
        end

        // truncated toward zero already, negation keeps that
        if (res.sign_q) begin
            word = -sat_mag;    // 32768 wraps to 8000 as wanted
        end else begin
            word = sat_mag;
        end
    end

    // ------------------------------------------------------------------------
    // output word
    // ------------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            quotient <= '0;
        end else if (finish) begin
            quotient <= word;   // held through back-pressure
        end
    end

endmodule

// File: src/restoring_div_core.sv
`timescale 1ns/10ps

module restoring_div_core (
    input  logic                clock,
    input  logic                reset,
    input  logic                start,  // load dividend and divisor
    input  logic                step,   // one restoring iteration
    input  fxdiv_pkg::div_req_t req,
    output fxdiv_pkg::div_res_t res
);

    logic [fxdiv_pkg::mag_w-1:0] acc;       // partial remainder, always below divisor
    logic [fxdiv_pkg::mag_w:0]   acc_sh;    // shifted remainder, one bit wider
    logic [fxdiv_pkg::mag_w:0]   acc_nxt;
    logic [fxdiv_pkg::quo_w-1:0] quo;       // dividend bits out, quotient bits in
    logic [fxdiv_pkg::quo_w-1:0] quo_nxt;
    logic [fxdiv_pkg::mag_w-1:0] dvsr;      // held divisor
    logic                        sign_q;

    // ------------------------------------------------------------------------
    // single restoring step
    // ------------------------------------------------------------------------
    always_comb begin
        acc_sh = {acc, quo[fxdiv_pkg::quo_w-1]};    // next dividend bit into remainder
        if (acc_sh >= {1'b0, dvsr}) begin
            acc_nxt = acc_sh - {1'b0, dvsr};        // fits, keep difference
            quo_nxt = {quo[fxdiv_pkg::quo_w-2:0], 1'b1};
        end else begin
            acc_nxt = acc_sh;                       // restore
            quo_nxt = {quo[fxdiv_pkg::quo_w-2:0], 1'b0};
        end
    end

    // ------------------------------------------------------------------------
    // state registers
    // ------------------------------------------------------------------------
    // divisor zero always subtracts, giving an all ones quotient
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            acc    <= '0;
            quo    <= '0;
            dvsr   <= '0;
            sign_q <= 1'b0;
        end else if (start) begin
            acc    <= '0;
            quo    <= {req.num_mag, {fxdiv_pkg::frac_shift{1'b0}}};    // num * 2^12
            dvsr   <= req.den_mag;
            sign_q <= req.sign_q;
        end else if (step) begin
            acc <= acc_nxt[fxdiv_pkg::mag_w-1:0];   // top bit is zero after restore
            quo <= quo_nxt;
        end
    end

    assign res.sign_q  = sign_q;
    assign res.quo_mag = quo;

endmodule

// File: tb/fx_divider_assertions.sv
`timescale 1ns/10ps

module fx_divider_assertions (
    input logic                               clock,
    input logic                               reset,
    input logic                               vld_in,
    input logic                               rdy_out,
    input logic                               vld_out,
    input logic                               rdy_in,
    input logic signed [fxdiv_pkg::out_w-1:0] quotient
);

    // ------------------------------------------------------------------------
    // handshake properties
    // ------------------------------------------------------------------------
    // idle and hold are separate states
    no_overlap: assert property (@(posedge clock) disable iff (reset)
        !(vld_out && rdy_out))
        else $error("vld_out and rdy_out high together");

    // result held under back-pressure
    result_held: assert property (@(posedge clock) disable iff (reset)
        vld_out && !rdy_in |=> vld_out && $stable(quotient))
        else $error("quotient or vld_out changed while rdy_in was low");

    // fixed latency is 30, bound at 32
    result_latency: assert property (@(posedge clock) disable iff (reset)
        vld_in && rdy_out |-> ##[1:32] vld_out)
        else $error("vld_out did not rise within 32 cycles of an accept");

endmodule

bind fx_divider fx_divider_assertions i_assertions (.*);

// File: tb/fx_divider_tb.sv
`timescale 1ns/10ps

module fx_divider_tb;

    localparam int n_random = 300;
    localparam int n_sat    = 16;
    localparam int n_zero   = 8;
    localparam int n_stall  = 40;
    localparam int n_edge   = 6;
    localparam int n_total  = n_random + n_sat + n_zero + n_stall + n_edge;

    // corner operands paired by index
    localparam logic [15:0] edge_num [n_edge] = '{16'h8000, 16'h8000, 16'h8000,
                                                  16'h0100, 16'h7fff, 16'hffff};
    localparam logic [15:0] edge_den [n_edge] = '{16'h8000, 16'h0100, 16'hffff,
                                                  16'hffff, 16'hffff, 16'h8000};

    logic                               clock;
    logic                               reset;
    logic                               vld_in;
    logic                               rdy_in;
    logic                               rdy_out;
    logic                               vld_out;
    fxdiv_pkg::fx_in_u                  numerator;
    fxdiv_pkg::fx_in_u                  denominator;
    logic signed [fxdiv_pkg::out_w-1:0] quotient;

    int seed   = 32'h0f3fd662;
    int checks = 0;
    int errors = 0;

    initial clock = 1'b0;
    always #20 clock = ~clock;     // 40 ns period

    fx_divider i_dut (
        .clock       (clock),
        .reset       (reset),
        .vld_in      (vld_in),
        .rdy_out     (rdy_out),
        .numerator   (numerator),
        .denominator (denominator),
        .vld_out     (vld_out),
        .rdy_in      (rdy_in),
        .quotient    (quotient)
    );

    // ------------------------------------------------------------------------
    // reference model for Q8.8 / Q8.8 -> Q4.12
    // ------------------------------------------------------------------------
    function automatic logic [15:0] model_quotient(input fxdiv_pkg::fx_in_u n,
                                                   input fxdiv_pkg::fx_in_u d);
        longint nm;
        longint dm;
        longint q;
        longint lim;
        logic   neg;
        nm  = n.fields.sign ? -longint'(n.word) : longint'(n.word);
        dm  = d.fields.sign ? -longint'(d.word) : longint'(d.word);
        neg = n.fields.sign ^ d.fields.sign;
        if (dm == 0) begin
            q = (longint'(1) << fxdiv_pkg::quo_w) - 1;     // all ones on zero divisor
        end else begin
            q = (nm * 4096) / dm;                           // truncates toward zero
        end
        lim = neg ? 32768 : 32767;
        if (q > lim) begin
            q = lim;
        end
        if (neg) begin
            q = -q;
        end
        return q[15:0];
    endfunction

    task automatic fail_check(input string what);
        errors++;
        $display("%s at %0t", what, $time);
    endtask

    task automatic check_word(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error: %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    // ------------------------------------------------------------------------
    // one transaction with stall cycles of rdy_in low after vld_out
    // ------------------------------------------------------------------------
    task automatic run_division(input fxdiv_pkg::fx_in_u n, input fxdiv_pkg::fx_in_u d,
                                input logic [15:0] expected, input int stall);
        int waited;
        @(posedge clock);
        numerator   <= n;
        denominator <= d;
        vld_in      <= 1'b1;
        rdy_in      <= (stall == 0);
        @(negedge clock);
        checks++;
        if (!rdy_out) begin
            fail_check("unit not ready for a new operand pair");
            @(posedge clock);
            vld_in <= 1'b0;
            return;
        end
        @(posedge clock);                   // transfer edge
        vld_in      <= 1'b0;
        numerator   <= $random(seed);       // operands must be registered by now
        denominator <= $random(seed);
        waited = 0;
        do begin
            @(negedge clock);
            waited++;
        end while (!vld_out && waited < 32);
        checks++;
        if (!vld_out) begin
            fail_check("no result within 32 cycles of the transfer");
            return;
        end
        check_word("quotient", expected, quotient);
        repeat (stall) begin
            @(negedge clock);
            checks++;
            if (!vld_out || rdy_out) begin
                fail_check("handshake changed while the result was held back");
            end
            check_word("quotient", expected, quotient);
        end
        if (stall > 0) begin
            @(posedge clock);
            rdy_in <= 1'b1;                 // consumed on the following edge
            @(negedge clock);
            check_word("quotient", expected, quotient);    // word offered on release
        end
        @(negedge clock);
        checks++;
        if (vld_out) begin
            fail_check("result not consumed while rdy_in was high");
        end
    endtask

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------
    initial begin
        fxdiv_pkg::fx_in_u  n;
        fxdiv_pkg::fx_in_u  d;
        logic signed [15:0] raw;
        int                 base;
        vld_in      = 1'b0;
        rdy_in      = 1'b1;
        numerator   = '0;
        denominator = '0;
        reset       = 1'b1;
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);

        base = errors;
        checks++;
        if (!rdy_out || vld_out) begin
            fail_check("wrong handshake state after reset");
        end
        $display("test 1 reset state: %0d errors", errors - base);

        base = errors;
        for (int i = 0; i < n_random; i++) begin
            n.word = $random(seed);
            raw    = $random(seed);
            d.word = raw >>> ($unsigned($random(seed)) % 12);  // spread of magnitudes
            run_division(n, d, model_quotient(n, d), 0);
        end
        $display("test 2 random operands: %0d divisions, %0d errors", n_random, errors - base);

        base = errors;
        for (int i = 0; i < n_sat; i++) begin
            raw    = $random(seed);
            n.word = i[0] ? {8'h80, raw[7:0]} : {8'h7f, raw[15:8]};  // near -128 / +128
            d.word = {8'h00, raw[7:0] | 8'h01};                       // below 1.0
            if (raw[8]) begin
                d.word = -d.word;
            end
            run_division(n, d, model_quotient(n, d), 0);
        end
        $display("test 3 saturation: %0d divisions, %0d errors", n_sat, errors - base);

        base = errors;
        for (int i = 0; i < n_zero; i++) begin
            n.word        = $random(seed);
            n.fields.sign = i[0];
            d.word        = '0;
            run_division(n, d, n.fields.sign ? 16'h8000 : 16'h7fff, 0);
        end
        $display("test 4 divide by zero: %0d divisions, %0d errors", n_zero, errors - base);

        base = errors;
        for (int i = 0; i < n_stall; i++) begin
            n.word = $random(seed);
            raw    = $random(seed);
            d.word = raw >>> ($unsigned($random(seed)) % 8);
            run_division(n, d, model_quotient(n, d), 1 + $unsigned($random(seed)) % 8);
        end
        $display("test 5 back-pressure: %0d divisions, %0d errors", n_stall, errors - base);

        base = errors;
        for (int i = 0; i < n_edge; i++) begin
            n.word = edge_num[i];
            d.word = edge_den[i];
            run_division(n, d, model_quotient(n, d), 0);
        end
        $display("test 6 edge operands: %0d divisions, %0d errors", n_edge, errors - base);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // watchdog allows 40 cycles per transaction plus margin
    initial begin
        repeat (n_total * 40 + 200) @(posedge clock);
        $display("timeout, the run did not complete in %0d cycles", n_total * 40 + 200);
        $display("Verification failed");
        $finish;
    end

endmodule
